// File: lsu_pkg.sv
package lsu_pkg;

    localparam int xlen = 64;
    localparam int strb_width = xlen / 8;

    typedef enum logic [3:0] {
        mem_lb,
        mem_lh,
        mem_lw,
        mem_ld,
        mem_lbu,
        mem_lhu,
        mem_lwu,
        mem_sb,
        mem_sh,
        mem_sw,
        mem_sd
    } mem_op_e;

    typedef enum logic [2:0] {
        idle,
        load_check_cache,
        load_pending,
        store_check_cache,
        store_pending
    } lsu_state_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

endpackage

// File: data_cache.sv
`timescale 1ns/1ps

module data_cache #(
    parameter int addr_width = 16,
    parameter int index_bits = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     write_enable,
    input  logic [addr_width-4:0]    waddr,
    input  logic [lsu_pkg::xlen-1:0] wdata,
    input  logic [addr_width-4:0]    raddr,
    output logic [lsu_pkg::xlen-1:0] rdata,
    output logic                     lookup_valid
);

    localparam int lines = 1 << index_bits;
    localparam int tag_bits = addr_width - 3 - index_bits;

    logic [lsu_pkg::xlen-1:0] data_mem [lines];
    logic [tag_bits-1:0] tag_mem [lines];
    logic [lines-1:0] line_valid;

    wire [index_bits-1:0] widx = waddr[index_bits-1:0];
    wire [index_bits-1:0] ridx = raddr[index_bits-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
        end else if (write_enable) begin
            line_valid[widx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            data_mem[widx] <= wdata;
            tag_mem[widx]  <= waddr[addr_width-4:index_bits];
        end
    end

    assign rdata = data_mem[ridx];
    assign lookup_valid = line_valid[ridx] && tag_mem[ridx] == raddr[addr_width-4:index_bits];

endmodule

// File: mem_request_stage.sv
`timescale 1ns/1ps

module mem_request_stage #(
    parameter int addr_width = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  lsu_pkg::mem_op_e               req_op,
    input  logic [addr_width-1:0]          req_addr,
    input  logic [lsu_pkg::xlen-1:0]       req_store_data,
    input  logic                           stall_next,
    output logic                           prev_stalled,
    output logic                           do_load,
    output logic                           do_store,
    output logic [addr_width-4:0]          aligned_addr,
    output logic [lsu_pkg::xlen-1:0]       store_data,
    output logic [lsu_pkg::strb_width-1:0] store_mask,
    output lsu_pkg::mem_op_e               hold_op,
    output logic [2:0]                     hold_offset,
    output logic                           misalign_fault,
    output logic                           misalign_done
);

    typedef enum logic [1:0] {
        st_empty,
        st_issue,
        st_wait
    } req_state_e;

    req_state_e state;
    logic [addr_width-1:0] hold_addr;
    logic [lsu_pkg::xlen-1:0] hold_data;
    logic [lsu_pkg::strb_width-1:0] size_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_empty;
        end else begin
            case (state)
                st_empty: begin
                    if (req_valid) begin
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    state <= misalign_fault ? st_empty : st_wait; // Faults skip the unit.
                end
                default: begin
                    if (!stall_next) begin
                        state <= st_empty;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            hold_op   <= req_op;
            hold_addr <= req_addr;
            hold_data <= req_store_data;
        end
    end

    // The low address bits inside the access size must be zero for natural alignment.
    always_comb begin
        size_mask = 8'h01;
        misalign_fault = 1'b0;
        case (hold_op)
            lsu_pkg::mem_lh, lsu_pkg::mem_lhu, lsu_pkg::mem_sh: begin
                size_mask = 8'h03;
                misalign_fault = hold_addr[0];
            end
            lsu_pkg::mem_lw, lsu_pkg::mem_lwu, lsu_pkg::mem_sw: begin
                size_mask = 8'h0f;
                misalign_fault = |hold_addr[1:0];
            end
            lsu_pkg::mem_ld, lsu_pkg::mem_sd: begin
                size_mask = 8'hff;
                misalign_fault = |hold_addr[2:0];
            end
            default: begin
                size_mask = 8'h01;
            end
        endcase
    end

    assign req_ready = state == st_empty;
    assign prev_stalled = !(state == st_issue && !misalign_fault);
    assign misalign_done = state == st_issue && misalign_fault;
    assign do_store = hold_op inside {lsu_pkg::mem_sb, lsu_pkg::mem_sh,
                                      lsu_pkg::mem_sw, lsu_pkg::mem_sd};
    assign do_load = hold_op inside {lsu_pkg::mem_lb, lsu_pkg::mem_lh, lsu_pkg::mem_lw,
                                     lsu_pkg::mem_ld, lsu_pkg::mem_lbu, lsu_pkg::mem_lhu,
                                     lsu_pkg::mem_lwu};
    assign hold_offset = hold_addr[2:0];
    assign aligned_addr = hold_addr[addr_width-1:3];
    assign store_mask = size_mask << hold_offset;
    assign store_data = hold_data << {hold_offset, 3'b000};

endmodule

// File: load_store.sv
`timescale 1ns/1ps

module load_store #(
    parameter int addr_width = 16,
    parameter int index_bits = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           prev_stalled,
    output logic                           stall_next,
    input  logic [addr_width-4:0]          aligned_addr,
    output logic                           access_fault,
    input  logic                           do_load,
    output logic [lsu_pkg::xlen-1:0]       load_data,
    input  logic                           do_store,
    input  logic [lsu_pkg::xlen-1:0]       store_data,
    input  logic [lsu_pkg::strb_width-1:0] store_mask,
    output logic                           arvalid,
    input  logic                           arready,
    output logic [addr_width-1:0]          araddr,
    input  logic                           rvalid,
    output logic                           rready,
    input  logic [lsu_pkg::xlen-1:0]       rdata,
    input  lsu_pkg::axil_resp_e            rresp,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [addr_width-1:0]          awaddr,
    output logic                           wvalid,
    input  logic                           wready,
    output logic [lsu_pkg::xlen-1:0]       wdata,
    output logic [lsu_pkg::strb_width-1:0] wstrb,
    input  logic                           bvalid,
    output logic                           bready,
    input  lsu_pkg::axil_resp_e            bresp
);

    lsu_pkg::lsu_state_e state;
    logic [addr_width-4:0] addr_buf;
    logic [lsu_pkg::xlen-1:0] store_data_buf;
    logic [lsu_pkg::strb_width-1:0] store_mask_buf;
    logic cache_we;
    logic [lsu_pkg::xlen-1:0] cache_wdata;
    logic [lsu_pkg::xlen-1:0] cache_rdata;
    logic cache_hit;
    logic aw_pending;
    logic w_pending;

    wire aw_done = (awvalid && awready) || aw_pending;
    wire w_done = (wvalid && wready) || w_pending;
    wire store_done = aw_done && w_done;

    always_ff @(posedge clk) begin
        if (!prev_stalled) begin
            addr_buf       <= aligned_addr;
            store_data_buf <= store_data;
            store_mask_buf <= store_mask;
        end
    end

    data_cache #(
        .addr_width(addr_width),
        .index_bits(index_bits)
    ) i_data_cache (
        .clk         (clk),
        .rst         (rst),
        .write_enable(cache_we),
        .waddr       (addr_buf),
        .wdata       (cache_wdata),
        .raddr       (addr_buf),
        .rdata       (cache_rdata),
        .lookup_valid(cache_hit)
    );

    // Fills only take good read data, so a faulting address never hits later.
    always_comb begin
        cache_we = 1'b0;
        cache_wdata = rdata;
        if (state == lsu_pkg::load_pending) begin
            cache_we = rvalid && rresp == lsu_pkg::resp_okay;
        end else if (state == lsu_pkg::store_check_cache) begin
            cache_we = cache_hit;
            for (int i = 0; i < lsu_pkg::strb_width; i++) begin
                cache_wdata[i*8 +: 8] = store_mask_buf[i] ? store_data_buf[i*8 +: 8]
                                                          : cache_rdata[i*8 +: 8];
            end
        end
    end

    always_comb begin
        stall_next = 1'b1;
        access_fault = 1'b0;
        load_data = '0;
        case (state)
            lsu_pkg::load_check_cache: begin
                stall_next = !cache_hit;
                load_data = cache_rdata;
            end
            lsu_pkg::load_pending: begin
                stall_next = !rvalid;
                access_fault = rresp != lsu_pkg::resp_okay;
                load_data = rdata;
            end
            lsu_pkg::store_check_cache, lsu_pkg::store_pending: begin
                stall_next = !store_done;
            end
            default: begin
                stall_next = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::idle;
        end else begin
            case (state)
                lsu_pkg::idle: begin
                    if (!prev_stalled && do_load) begin
                        state <= lsu_pkg::load_check_cache;
                    end else if (!prev_stalled && do_store) begin
                        state <= lsu_pkg::store_check_cache;
                    end
                end
                lsu_pkg::load_check_cache: begin
                    if (cache_hit) begin
                        state <= lsu_pkg::idle;
                    end else if (arready) begin
                        state <= lsu_pkg::load_pending;
                    end
                end
                lsu_pkg::load_pending: begin
                    if (rvalid) begin
                        state <= lsu_pkg::idle;
                    end
                end
                lsu_pkg::store_check_cache: begin
                    state <= store_done ? lsu_pkg::idle : lsu_pkg::store_pending;
                end
                default: begin
                    if (store_done) begin
                        state <= lsu_pkg::idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (!prev_stalled && do_store) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            awvalid <= awvalid && !awready;
            wvalid  <= wvalid && !wready;
        end
    end

    // Either channel may finish first; remember it until the other one does.
    always_ff @(posedge clk) begin
        if (rst || store_done) begin
            aw_pending <= 1'b0;
            w_pending  <= 1'b0;
        end else begin
            aw_pending <= aw_pending || (awvalid && awready);
            w_pending  <= w_pending || (wvalid && wready);
        end
    end

    assign arvalid = state == lsu_pkg::load_check_cache && !cache_hit;
    assign araddr = {addr_buf, 3'b000};
    assign rready = state == lsu_pkg::load_pending;
    assign awaddr = {addr_buf, 3'b000};
    assign wdata = store_data_buf;
    assign wstrb = store_mask_buf;
    assign bready = 1'b1;

    a_one_op: assert property (@(posedge clk) disable iff (rst)
        !prev_stalled |-> do_load ^ do_store);
    a_addr_known: assert property (@(posedge clk) disable iff (rst)
        !prev_stalled |-> !$isunknown(aligned_addr));
    a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> bresp == lsu_pkg::resp_okay);

endmodule

// File: load_align_stage.sv
`timescale 1ns/1ps

module load_align_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     done,
    input  logic [lsu_pkg::xlen-1:0] load_data,
    input  logic                     access_fault,
    input  lsu_pkg::mem_op_e         hold_op,
    input  logic [2:0]               hold_offset,
    input  logic                     misalign_fault,
    input  logic                     misalign_done,
    output logic                     rsp_valid,
    output logic [lsu_pkg::xlen-1:0] rsp_data,
    output logic                     rsp_fault,
    output logic                     rsp_is_store
);

    localparam int xlen = lsu_pkg::xlen;

    logic [xlen-1:0] lane;
    logic [xlen-1:0] extended;
    logic fault;
    logic is_store;

    always_comb begin
        lane = load_data >> {hold_offset, 3'b000}; // Addressed byte lands in lane zero.
        is_store = hold_op inside {lsu_pkg::mem_sb, lsu_pkg::mem_sh,
                                   lsu_pkg::mem_sw, lsu_pkg::mem_sd};
        fault = misalign_done ? misalign_fault : access_fault;
        case (hold_op)
            lsu_pkg::mem_lb:  extended = {{(xlen-8){lane[7]}}, lane[7:0]};
            lsu_pkg::mem_lh:  extended = {{(xlen-16){lane[15]}}, lane[15:0]};
            lsu_pkg::mem_lw:  extended = {{(xlen-32){lane[31]}}, lane[31:0]};
            lsu_pkg::mem_ld:  extended = lane;
            lsu_pkg::mem_lbu: extended = {{(xlen-8){1'b0}}, lane[7:0]};
            lsu_pkg::mem_lhu: extended = {{(xlen-16){1'b0}}, lane[15:0]};
            lsu_pkg::mem_lwu: extended = {{(xlen-32){1'b0}}, lane[31:0]};
            default:          extended = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= done || misalign_done;
        end
    end

    always_ff @(posedge clk) begin
        if (done || misalign_done) begin
            rsp_data     <= fault ? '0 : extended;
            rsp_fault    <= fault;
            rsp_is_store <= is_store;
        end
    end

endmodule

// File: axil_data_ram.sv
`timescale 1ns/1ps

module axil_data_ram #(
    parameter int addr_width  = 16,
    parameter int ram_words   = 1024,
    parameter int ram_latency = 2
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [addr_width-1:0]          araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [lsu_pkg::xlen-1:0]       rdata,
    output lsu_pkg::axil_resp_e            rresp,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [addr_width-1:0]          awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [lsu_pkg::xlen-1:0]       wdata,
    input  logic [lsu_pkg::strb_width-1:0] wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output lsu_pkg::axil_resp_e            bresp
);

    localparam int word_bits = $clog2(ram_words);
    localparam int cnt_bits = $clog2(ram_latency + 1);
    localparam logic [cnt_bits-1:0] cnt_start = cnt_bits'(ram_latency - 1);

    logic [lsu_pkg::xlen-1:0] mem [ram_words];
    logic [1:0] rsp_busy; // Index 0 is the read channel, index 1 the write channel.
    logic [cnt_bits-1:0] rsp_cnt [2];

    wire rd_in_range = araddr[addr_width-1:3] < ram_words;
    wire wr_in_range = awaddr[addr_width-1:3] < ram_words;
    wire wr_fire = awvalid && wvalid;
    wire [1:0] rsp_start = {wr_fire, arvalid};
    wire [1:0] rsp_ack = {bvalid && bready, rvalid && rready};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rst) begin
                rsp_busy[i] <= 1'b0;
                rsp_cnt[i]  <= '0;
            end else if (rsp_start[i]) begin
                rsp_busy[i] <= 1'b1;
                rsp_cnt[i]  <= cnt_start;
            end else if (rsp_ack[i]) begin
                rsp_busy[i] <= 1'b0;
            end else if (rsp_cnt[i] != '0) begin
                rsp_cnt[i] <= rsp_cnt[i] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid) begin
            rdata <= rd_in_range ? mem[araddr[word_bits+2:3]] : '0;
            rresp <= rd_in_range ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
        end
        if (wr_fire && wr_in_range) begin
            for (int i = 0; i < lsu_pkg::strb_width; i++) begin
                if (wstrb[i]) begin
                    mem[awaddr[word_bits+2:3]][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    assign arready = arvalid;
    assign awready = wr_fire;
    assign wready = wr_fire;
    assign rvalid = rsp_busy[0] && rsp_cnt[0] == '0;
    assign bvalid = rsp_busy[1] && rsp_cnt[1] == '0;
    assign bresp = lsu_pkg::resp_okay; // Out-of-range writes are dropped silently.

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !((arvalid && rsp_busy[0]) || (awvalid && rsp_busy[1])));

endmodule

// File: lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem #(
    parameter int addr_width  = 16,
    parameter int index_bits  = 4,
    parameter int ram_words   = 1024,
    parameter int ram_latency = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  lsu_pkg::mem_op_e         req_op,
    input  logic [addr_width-1:0]    req_addr,
    input  logic [lsu_pkg::xlen-1:0] req_store_data,
    output logic                     rsp_valid,
    output logic [lsu_pkg::xlen-1:0] rsp_data,
    output logic                     rsp_fault,
    output logic                     rsp_is_store
);

    logic stall_next, prev_stalled, do_load, do_store;
    logic [addr_width-4:0] aligned_addr;
    logic [lsu_pkg::xlen-1:0] store_data, load_data;
    logic [lsu_pkg::strb_width-1:0] store_mask;
    lsu_pkg::mem_op_e hold_op;
    logic [2:0] hold_offset;
    logic misalign_fault, misalign_done, access_fault;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
    logic [addr_width-1:0] araddr, awaddr;
    logic [lsu_pkg::xlen-1:0] rdata, wdata;
    logic [lsu_pkg::strb_width-1:0] wstrb;
    lsu_pkg::axil_resp_e rresp, bresp;

    mem_request_stage #(.addr_width(addr_width)) i_request (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready),
        .req_op(req_op), .req_addr(req_addr), .req_store_data(req_store_data),
        .stall_next(stall_next), .prev_stalled(prev_stalled), .do_load(do_load),
        .do_store(do_store), .aligned_addr(aligned_addr), .store_data(store_data),
        .store_mask(store_mask), .hold_op(hold_op), .hold_offset(hold_offset),
        .misalign_fault(misalign_fault), .misalign_done(misalign_done)
    );

    load_store #(.addr_width(addr_width), .index_bits(index_bits)) i_load_store (
        .clk(clk), .rst(rst), .prev_stalled(prev_stalled), .stall_next(stall_next),
        .aligned_addr(aligned_addr), .access_fault(access_fault), .do_load(do_load),
        .load_data(load_data), .do_store(do_store), .store_data(store_data),
        .store_mask(store_mask), .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .wvalid(wvalid),
        .wready(wready), .wdata(wdata), .wstrb(wstrb), .bvalid(bvalid),
        .bready(bready), .bresp(bresp)
    );

    // Completion is the one cycle in which the unit stops stalling.
    load_align_stage i_align (
        .clk(clk), .rst(rst), .done(!stall_next), .load_data(load_data),
        .access_fault(access_fault), .hold_op(hold_op), .hold_offset(hold_offset),
        .misalign_fault(misalign_fault), .misalign_done(misalign_done),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_fault(rsp_fault),
        .rsp_is_store(rsp_is_store)
    );

    axil_data_ram #(
        .addr_width(addr_width), .ram_words(ram_words), .ram_latency(ram_latency)
    ) i_ram (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .wvalid(wvalid),
        .wready(wready), .wdata(wdata), .wstrb(wstrb), .bvalid(bvalid),
        .bready(bready), .bresp(bresp)
    );

endmodule

// File: tb_lsu_vectors.svh
`ifndef tb_lsu_vectors_svh
`define tb_lsu_vectors_svh

// Each row gives the opcode, the byte address, the store data, whether the store data
// is random and whether req_valid stays high into the next row.
task automatic fill_table();
    add_entry(lsu_pkg::mem_sd,  16'h0100, 64'h8123_4567_f9ab_cdef, 0, 0);
    add_entry(lsu_pkg::mem_ld,  16'h0100, 64'h0, 0, 1); // Miss fills line 0.
    add_entry(lsu_pkg::mem_lw,  16'h0104, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lwu, 16'h0104, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lh,  16'h0102, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lhu, 16'h0106, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lb,  16'h0107, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lbu, 16'h0101, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_ld,  16'h0100, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_sb,  16'h0100, 64'h5a, 0, 0); // Store hits and merges into the line.
    add_entry(lsu_pkg::mem_sh,  16'h0104, 64'h0, 1, 1);
    add_entry(lsu_pkg::mem_ld,  16'h0100, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_sw,  16'h0148, 64'h0, 1, 1);
    add_entry(lsu_pkg::mem_sw,  16'h014c, 64'hffff_ffff_8000_0001, 0, 1);
    add_entry(lsu_pkg::mem_ld,  16'h0148, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lw,  16'h014c, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lwu, 16'h014c, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lw,  16'h0148, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_sw,  16'h0148, 64'h0000_0000_1234_5678, 0, 0);
    add_entry(lsu_pkg::mem_ld,  16'h0148, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_sh,  16'h0180, 64'hf00d, 0, 1); // Same cache index as 0x0100.
    add_entry(lsu_pkg::mem_sh,  16'h0182, 64'h0, 1, 1);
    add_entry(lsu_pkg::mem_sh,  16'h0184, 64'h8001, 0, 1);
    add_entry(lsu_pkg::mem_sh,  16'h0186, 64'h7fff, 0, 1);
    add_entry(lsu_pkg::mem_ld,  16'h0180, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lh,  16'h0184, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lhu, 16'h0184, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lh,  16'h0186, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_sd,  16'h01c0, 64'h0, 1, 0);
    add_entry(lsu_pkg::mem_sb,  16'h01c3, 64'h80, 0, 1);
    add_entry(lsu_pkg::mem_sb,  16'h01c5, 64'h7f, 0, 1);
    add_entry(lsu_pkg::mem_lb,  16'h01c3, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lbu, 16'h01c3, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lb,  16'h01c5, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_ld,  16'h01c0, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_sd,  16'h0200, 64'h0, 1, 0);
    add_entry(lsu_pkg::mem_ld,  16'h0200, 64'h0, 0, 0); // The first load misses and the repeat hits.
    add_entry(lsu_pkg::mem_ld,  16'h0200, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_sd,  16'h0010, 64'h0, 1, 0);
    add_entry(lsu_pkg::mem_ld,  16'h2010, 64'h0, 0, 0); // Lies beyond the RAM and aliases 0x0010.
    add_entry(lsu_pkg::mem_sd,  16'h2010, 64'h0, 1, 0);
    add_entry(lsu_pkg::mem_sb,  16'h3fff, 64'h11, 0, 0);
    add_entry(lsu_pkg::mem_ld,  16'h0010, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_ld,  16'h2010, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_lw,  16'hfff8, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_lh,  16'h0101, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lw,  16'h0102, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_ld,  16'h0104, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_sw,  16'h0102, 64'hdead_beef, 0, 1);
    add_entry(lsu_pkg::mem_lhu, 16'h0203, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_lwu, 16'h0206, 64'h0, 0, 1);
    add_entry(lsu_pkg::mem_sd,  16'h0103, 64'h0, 1, 1);
    add_entry(lsu_pkg::mem_sh,  16'h0105, 64'hbeef, 0, 0);
    add_entry(lsu_pkg::mem_ld,  16'h0100, 64'h0, 0, 0);
    add_entry(lsu_pkg::mem_ld,  16'h0200, 64'h0, 0, 0);
endtask

`endif

// File: tb_lsu_subsystem.sv
`timescale 1ns/1ps

module tb_lsu_subsystem;

    localparam int addr_width = 16;
    localparam int index_bits = 4;
    localparam int ram_words = 1024;
    localparam int ram_latency = 2;
    localparam int xlen = lsu_pkg::xlen;
    localparam int clk_period = 10;
    localparam int table_max = 64;
    localparam int wait_limit = 40; // Cycles one entry may take before it counts as stuck.

    logic clk;
    logic rst;
    logic req_valid;
    logic req_ready;
    lsu_pkg::mem_op_e req_op;
    logic [addr_width-1:0] req_addr;
    logic [xlen-1:0] req_store_data;
    logic rsp_valid;
    logic [xlen-1:0] rsp_data;
    logic rsp_fault;
    logic rsp_is_store;

    lsu_pkg::mem_op_e tbl_op [table_max];
    logic [addr_width-1:0] tbl_addr [table_max];
    logic [xlen-1:0] tbl_data [table_max];
    bit tbl_hold [table_max];
    int tbl_len = 0;
    bit table_ready = 1'b0;

    logic [7:0] ref_mem [ram_words*8]; // Bytes of the RAM stay X until a store writes them.
    integer seed = 32'h66db_0ddd;
    int checks = 0;
    int errors = 0;

    lsu_subsystem #(
        .addr_width(addr_width), .index_bits(index_bits),
        .ram_words(ram_words), .ram_latency(ram_latency)
    ) i_dut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready),
        .req_op(req_op), .req_addr(req_addr), .req_store_data(req_store_data),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_fault(rsp_fault),
        .rsp_is_store(rsp_is_store)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic add_entry(input lsu_pkg::mem_op_e op, input logic [addr_width-1:0] addr,
                             input logic [xlen-1:0] data, input bit rnd, input bit hold);
        tbl_op[tbl_len] = op;
        tbl_addr[tbl_len] = addr;
        tbl_data[tbl_len] = rnd ? {$random(seed), $random(seed)} : data;
        tbl_hold[tbl_len] = hold;
        tbl_len++;
    endtask

    `include "tb_lsu_vectors.svh"

    function automatic int access_size(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::mem_lb, lsu_pkg::mem_lbu, lsu_pkg::mem_sb: return 1;
            lsu_pkg::mem_lh, lsu_pkg::mem_lhu, lsu_pkg::mem_sh: return 2;
            lsu_pkg::mem_lw, lsu_pkg::mem_lwu, lsu_pkg::mem_sw: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic bit is_store_op(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::mem_sb, lsu_pkg::mem_sh, lsu_pkg::mem_sw, lsu_pkg::mem_sd};
    endfunction

    function automatic string state_name();
        return i_dut.i_load_store.state.name();
    endfunction

    // Works out the response of entry k and applies its store to the reference memory.
    task automatic expect_for(input int k, output logic [xlen-1:0] data, output logic fault);
        int size;
        bit signed_op;
        logic [xlen-1:0] raw;
        size = access_size(tbl_op[k]);
        signed_op = tbl_op[k] inside {lsu_pkg::mem_lb, lsu_pkg::mem_lh, lsu_pkg::mem_lw};
        data = '0;
        fault = 1'b0;
        raw = '0;
        if (tbl_addr[k] % size != 0) begin
            fault = 1'b1;
        end else if ((tbl_addr[k] >> 3) >= ram_words) begin
            fault = !is_store_op(tbl_op[k]); // Out-of-range stores are acknowledged and lost.
        end else if (is_store_op(tbl_op[k])) begin
            for (int i = 0; i < size; i++) begin
                ref_mem[tbl_addr[k] + i] = tbl_data[k][i*8 +: 8];
            end
        end else begin
            for (int i = 0; i < size; i++) begin
                raw[i*8 +: 8] = ref_mem[tbl_addr[k] + i];
            end
            if ($isunknown(raw)) begin
                $display("Entry %0d loads bytes that no earlier store wrote", k);
                errors++;
            end
            data = raw;
            for (int i = size * 8; i < xlen; i++) begin
                data[i] = signed_op ? raw[size*8-1] : 1'b0;
            end
        end
    endtask

    task automatic check_data(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic present(input int k);
        req_valid = 1'b1;
        req_op = tbl_op[k];
        req_addr = tbl_addr[k];
        req_store_data = tbl_data[k];
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        logic [xlen-1:0] exp_data;
        logic exp_fault;
        int waited;
        bit stuck;
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = lsu_pkg::mem_lb;
        req_addr = '0;
        req_store_data = '0;
        stuck = 1'b0;
        fill_table();
        table_ready = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
        present(0);
        for (int k = 0; k < tbl_len && !stuck; k++) begin
            waited = 0;
            while (!req_ready && waited < wait_limit) begin
                @(negedge clk);
                waited++;
            end
            if (!req_ready) begin
                $display("Entry %0d was never accepted, unit state %s", k, state_name());
                errors++;
                stuck = 1'b1;
            end else begin
                @(negedge clk); // The request was taken on the edge just passed.
                if (tbl_hold[k] && k + 1 < tbl_len) begin
                    present(k + 1);
                end else begin
                    req_valid = 1'b0;
                end
                check_flag(rsp_valid, 1'b0, $sformatf("entry %0d early rsp_valid", k));
                waited = 0;
                while (!rsp_valid && waited < wait_limit) begin
                    check_flag(req_ready, 1'b0, $sformatf("entry %0d req_ready while busy", k));
                    @(negedge clk);
                    waited++;
                end
                if (!rsp_valid) begin
                    $display("Entry %0d got no response, unit state %s", k, state_name());
                    errors++;
                    stuck = 1'b1;
                end else begin
                    expect_for(k, exp_data, exp_fault);
                    check_data(rsp_data, exp_data, $sformatf("entry %0d data", k));
                    check_flag(rsp_fault, exp_fault, $sformatf("entry %0d fault", k));
                    check_flag(rsp_is_store, is_store_op(tbl_op[k]),
                               $sformatf("entry %0d is_store", k));
                    if (!tbl_hold[k] && k + 1 < tbl_len) begin
                        @(negedge clk);
                        present(k + 1);
                    end
                end
            end
        end
        req_valid = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_flag(rsp_valid, 1'b0, "rsp_valid after the last response");
        end
        finish_run();
    end

    initial begin
        wait (table_ready);
        #((tbl_len * 40 + 16) * clk_period);
        $display("Timeout after %0d cycles, unit state %s", tbl_len * 40 + 16, state_name());
        errors++;
        finish_run();
    end

endmodule

// File: verilog.f
+incdir+.
lsu_pkg.sv
data_cache.sv
mem_request_stage.sv
load_store.sv
load_align_stage.sv
axil_data_ram.sv
lsu_subsystem.sv
tb_lsu_subsystem.sv
